// File: compile.f
verilog/stream_app_pkg.sv
verilog/pcis_write_slave.sv
verilog/csr_write_slave.sv
verilog/stream_arbiter.sv
verilog/stream_fifo.sv
verilog/ddr_line_writer.sv
verilog/done_irq.sv
verilog/stream_app_top.sv
test/stream_app_tb.sv

// File: test/stream_app_tb.sv
`default_nettype none

module stream_app_tb import stream_app_pkg::*; ();

    localparam word_t SEED = 32'h8037_30bf;
    localparam int NROWS = 13;
    localparam int WAIT_LIMIT = 2000;
    localparam int SIG_PCIS_AW = 0;
    localparam int SIG_PCIS_W = 1;
    localparam int SIG_PCIS_B = 2;
    localparam int SIG_CSR_AW = 3;
    localparam int SIG_CSR_W = 4;
    localparam int SIG_CSR_B = 5;
    localparam int SIG_IRQ = 6;
    localparam int SIG_HOST_IDLE = 7;

    typedef enum int {ROW_HOST, ROW_INJECT, ROW_DONE, ROW_ALLOW, ROW_ZERO} row_kind_t;

    logic       clk, rstn;
    logic       pcis_awvalid, pcis_awready, pcis_wvalid, pcis_wready;
    logic       pcis_bvalid, pcis_bready;
    axi_id_t    pcis_awid, pcis_bid;
    burst_len_t pcis_awlen;
    line_t      pcis_wdata;
    logic       csr_awvalid, csr_awready, csr_wvalid, csr_wready, csr_bvalid, csr_bready;
    csr_addr_t  csr_awaddr;
    word_t      csr_wdata;
    logic       ddr_awvalid, ddr_awready, ddr_wvalid, ddr_wready, irq;
    ddr_addr_t  ddr_awaddr;
    line_t      ddr_wdata;

    row_kind_t  row_kind [NROWS];
    burst_len_t row_len [NROWS];
    axi_id_t    row_id [NROWS];
    word_t      row_data [NROWS];

    word_t      ref_words [$];
    ddr_addr_t  got_addrs [$];
    line_t      got_lines [$];
    word_t      data_rng = SEED;
    word_t      mem_rng = SEED;
    int         mismatch_cnt = 0;
    int         fail_cnt = 0;
    int         irq_cnt = 0;
    int         lines_at_irq = 0;
    logic       allow_sent = 1'b0;
    logic       early_write_seen = 1'b0;

    stream_app_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic sel_signal(input int which);
        case (which)
            SIG_PCIS_AW: return pcis_awready;
            SIG_PCIS_W:  return pcis_wready;
            SIG_PCIS_B:  return pcis_bvalid;
            SIG_CSR_AW:  return csr_awready;
            SIG_CSR_W:   return csr_wready;
            SIG_CSR_B:   return csr_bvalid;
            SIG_IRQ:     return irq;
            // host words still queued ahead of an inject
            default:     return !UUT.host_s_valid;
        endcase
    endfunction

    // returns 1 unit after the edge where the signal was seen high
    task automatic wait_for(input int which, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!sel_signal(which) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!sel_signal(which)) begin
            $display("timeout while waiting for %s", what);
            fail_cnt++;
        end
        #1;
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bid(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input ddr_addr_t got, input ddr_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic set_row(input int i, input row_kind_t kind, input burst_len_t len,
                           input axi_id_t id, input word_t data);
        row_kind[i] = kind;
        row_len[i] = len;
        row_id[i] = id;
        row_data[i] = data;
    endtask

    task automatic host_burst(input axi_id_t id, input burst_len_t len);
        line_t beat;
        pcis_awvalid = 1'b1;
        pcis_awid = id;
        pcis_awlen = len;
        wait_for(SIG_PCIS_AW, "host address ready");
        pcis_awvalid = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                data_rng = xorshift32(data_rng);
                beat[w*WORD_W +: WORD_W] = data_rng;
                ref_words.push_back(data_rng);
            end
            pcis_wvalid = 1'b1;
            pcis_wdata = beat;
            wait_for(SIG_PCIS_W, "host data ready");
            pcis_wvalid = 1'b0;
        end
        pcis_bready = 1'b1;
        wait_for(SIG_PCIS_B, "host write response");
        pcis_bready = 1'b0;
        check_bid("pcis_bid", pcis_bid, id);
    endtask

    task automatic csr_write(input csr_addr_t addr, input word_t data);
        csr_awvalid = 1'b1;
        csr_awaddr = addr;
        wait_for(SIG_CSR_AW, "register address ready");
        csr_awvalid = 1'b0;
        csr_wvalid = 1'b1;
        csr_wdata = data;
        wait_for(SIG_CSR_W, "register data ready");
        csr_wvalid = 1'b0;
        csr_bready = 1'b1;
        wait_for(SIG_CSR_B, "register write response");
        csr_bready = 1'b0;
    endtask

    // memory side with random ready
    initial begin
        ddr_awready = 1'b0;
        ddr_wready = 1'b0;
        forever begin
            @(posedge clk);
            if (rstn) begin
                if (ddr_awvalid && ddr_awready) got_addrs.push_back(ddr_awaddr);
                if (ddr_wvalid && ddr_wready) got_lines.push_back(ddr_wdata);
                if ((ddr_awvalid || ddr_wvalid) && !allow_sent && !early_write_seen) begin
                    $display("memory write started before writes were allowed");
                    fail_cnt++;
                    early_write_seen = 1'b1;
                end
                if (irq) begin
                    irq_cnt++;
                    lines_at_irq = got_lines.size();
                end
            end
            #1;
            mem_rng = xorshift32(mem_rng);
            ddr_awready = (mem_rng[1:0] != 2'b00);
            ddr_wready = (mem_rng[9:8] != 2'b00);
        end
    end

    initial begin
        int n_words;
        int n_lines;
        int k;
        line_t exp_line;
        rstn = 1'b0;
        pcis_awvalid = 1'b0;
        pcis_awid = '0;
        pcis_awlen = '0;
        pcis_wvalid = 1'b0;
        pcis_wdata = '0;
        pcis_bready = 1'b0;
        csr_awvalid = 1'b0;
        csr_awaddr = '0;
        csr_wvalid = 1'b0;
        csr_wdata = '0;
        csr_bready = 1'b0;

        // first two bursts sit in the FIFO until allow
        set_row(0, ROW_HOST, 8'd1, 6'd3, '0);
        set_row(1, ROW_HOST, 8'd0, 6'd5, '0);
        set_row(2, ROW_INJECT, '0, '0, 32'hc0de_0001);
        set_row(3, ROW_ZERO, '0, '0, 32'hdead_beef);
        set_row(4, ROW_ALLOW, '0, '0, 32'h1);
        set_row(5, ROW_HOST, 8'd2, 6'd9, '0);
        set_row(6, ROW_INJECT, '0, '0, 32'hc0de_0002);
        set_row(7, ROW_HOST, 8'd0, 6'd17, '0);
        set_row(8, ROW_INJECT, '0, '0, 32'hc0de_0003);
        set_row(9, ROW_INJECT, '0, '0, 32'hc0de_0004);
        set_row(10, ROW_HOST, 8'd1, 6'd42, '0);
        set_row(11, ROW_INJECT, '0, '0, 32'hc0de_0005);
        set_row(12, ROW_DONE, '0, '0, 32'h1);

        repeat (8) @(posedge clk);
        check_flag("irq", irq, 1'b0);
        check_flag("pcis_awready", pcis_awready, 1'b0);
        check_flag("pcis_bvalid", pcis_bvalid, 1'b0);
        check_flag("csr_bvalid", csr_bvalid, 1'b0);
        check_flag("ddr_awvalid", ddr_awvalid, 1'b0);
        check_flag("ddr_wvalid", ddr_wvalid, 1'b0);
        #1 rstn = 1'b1;
        @(posedge clk);
        #1;

        for (int i = 0; i < NROWS; i++) begin
            case (row_kind[i])
                ROW_HOST: host_burst(row_id[i], row_len[i]);
                ROW_INJECT: begin
                    wait_for(SIG_HOST_IDLE, "host stream to drain");
                    ref_words.push_back(row_data[i]);
                    csr_write(CSR_INJECT_ADDR, row_data[i]);
                end
                ROW_DONE: csr_write(CSR_DONE_ADDR, row_data[i]);
                ROW_ALLOW: begin
                    allow_sent = 1'b1;
                    csr_write(CSR_ALLOW_ADDR, row_data[i]);
                end
                default: csr_write(32'd0, row_data[i]);
            endcase
        end

        wait_for(SIG_IRQ, "interrupt after done");
        // window for a second pulse
        repeat (40) @(posedge clk);

        n_words = ref_words.size();
        n_lines = (n_words + WORDS_PER_LINE - 1) / WORDS_PER_LINE;
        if (got_lines.size() != n_lines || got_addrs.size() != n_lines) begin
            $display("expected %0d memory lines, saw %0d lines and %0d addresses",
                     n_lines, got_lines.size(), got_addrs.size());
            fail_cnt++;
        end
        for (int j = 0; j < n_lines && j < got_lines.size() && j < got_addrs.size(); j++) begin
            for (int p = 0; p < WORDS_PER_LINE; p++) begin
                k = j * WORDS_PER_LINE + p;
                // unfilled positions of the flush line repeat the previous line
                if (k < n_words) exp_line[p*WORD_W +: WORD_W] = ref_words[k];
                else if (j > 0) exp_line[p*WORD_W +: WORD_W] = ref_words[k - WORDS_PER_LINE];
                else exp_line[p*WORD_W +: WORD_W] = '0;
            end
            check_line($sformatf("ddr_wdata[%0d]", j), got_lines[j], exp_line);
            check_addr($sformatf("ddr_awaddr[%0d]", j), got_addrs[j],
                       ddr_addr_t'(j * LINE_BYTES));
        end
        if (irq_cnt != 1) begin
            $display("interrupt pulsed %0d times instead of once", irq_cnt);
            fail_cnt++;
        end
        if (lines_at_irq != n_lines) begin
            $display("interrupt came after %0d of %0d memory lines", lines_at_irq, n_lines);
            fail_cnt++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/stream_app_top.sv
`default_nettype none

module stream_app_top import stream_app_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       pcis_awvalid,
    input  axi_id_t    pcis_awid,
    input  burst_len_t pcis_awlen,
    output logic       pcis_awready,
    input  logic       pcis_wvalid,
    input  line_t      pcis_wdata,
    output logic       pcis_wready,
    output logic       pcis_bvalid,
    output axi_id_t    pcis_bid,
    input  logic       pcis_bready,
    input  logic       csr_awvalid,
    input  csr_addr_t  csr_awaddr,
    output logic       csr_awready,
    input  logic       csr_wvalid,
    input  word_t      csr_wdata,
    output logic       csr_wready,
    output logic       csr_bvalid,
    input  logic       csr_bready,
    output logic       ddr_awvalid,
    output ddr_addr_t  ddr_awaddr,
    input  logic       ddr_awready,
    output logic       ddr_wvalid,
    output line_t      ddr_wdata,
    input  logic       ddr_wready,
    output logic       irq
);

    logic   host_s_valid, host_s_last, host_s_ready;
    word_t  host_s_data;
    logic   csr_s_valid, csr_s_last, csr_s_ready;
    word_t  csr_s_data;
    logic   arb_valid, arb_last, arb_ready;
    word_t  arb_data;
    logic   fifo_valid, fifo_ready, fifo_empty;
    word_t  fifo_data;
    logic   allow_writes, app_done, flush;
    count_t inject_cnt;

    pcis_write_slave u_pcis (
        .clk(clk), .rstn(rstn),
        .pcis_awvalid(pcis_awvalid), .pcis_awid(pcis_awid), .pcis_awlen(pcis_awlen),
        .pcis_awready(pcis_awready),
        .pcis_wvalid(pcis_wvalid), .pcis_wdata(pcis_wdata), .pcis_wready(pcis_wready),
        .pcis_bvalid(pcis_bvalid), .pcis_bid(pcis_bid), .pcis_bready(pcis_bready),
        .host_s_valid(host_s_valid), .host_s_data(host_s_data),
        .host_s_last(host_s_last), .host_s_ready(host_s_ready)
    );

    csr_write_slave u_csr (
        .clk(clk), .rstn(rstn),
        .csr_awvalid(csr_awvalid), .csr_awaddr(csr_awaddr), .csr_awready(csr_awready),
        .csr_wvalid(csr_wvalid), .csr_wdata(csr_wdata), .csr_wready(csr_wready),
        .csr_bvalid(csr_bvalid), .csr_bready(csr_bready),
        .csr_s_valid(csr_s_valid), .csr_s_data(csr_s_data),
        .csr_s_last(csr_s_last), .csr_s_ready(csr_s_ready),
        .allow_writes(allow_writes), .app_done(app_done), .inject_cnt(inject_cnt)
    );

    stream_arbiter u_arb (
        .clk(clk), .rstn(rstn),
        .csr_s_valid(csr_s_valid), .csr_s_data(csr_s_data),
        .csr_s_last(csr_s_last), .csr_s_ready(csr_s_ready),
        .host_s_valid(host_s_valid), .host_s_data(host_s_data),
        .host_s_last(host_s_last), .host_s_ready(host_s_ready),
        .arb_valid(arb_valid), .arb_data(arb_data),
        .arb_last(arb_last), .arb_ready(arb_ready)
    );

    // last is dropped here, the writer packs by count
    stream_fifo u_fifo (
        .clk(clk), .rstn(rstn),
        .arb_valid(arb_valid), .arb_data(arb_data), .arb_ready(arb_ready),
        .fifo_valid(fifo_valid), .fifo_data(fifo_data), .fifo_ready(fifo_ready),
        .fifo_empty(fifo_empty)
    );

    ddr_line_writer u_writer (
        .clk(clk), .rstn(rstn),
        .fifo_valid(fifo_valid), .fifo_data(fifo_data), .fifo_ready(fifo_ready),
        .allow_writes(allow_writes), .flush(flush),
        .ddr_awvalid(ddr_awvalid), .ddr_awaddr(ddr_awaddr), .ddr_awready(ddr_awready),
        .ddr_wvalid(ddr_wvalid), .ddr_wdata(ddr_wdata), .ddr_wready(ddr_wready)
    );

    done_irq u_done (
        .clk(clk), .rstn(rstn),
        .pcis_wvalid(pcis_wvalid), .pcis_wready(pcis_wready),
        .ddr_wvalid(ddr_wvalid), .ddr_wready(ddr_wready),
        .host_s_valid(host_s_valid), .csr_s_valid(csr_s_valid),
        .fifo_empty(fifo_empty), .fifo_valid(fifo_valid),
        .app_done(app_done), .inject_cnt(inject_cnt),
        .flush(flush), .irq(irq)
    );

endmodule

`default_nettype wire

// File: verilog/done_irq.sv
`default_nettype none

module done_irq import stream_app_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   pcis_wvalid,
    input  logic   pcis_wready,
    input  logic   ddr_wvalid,
    input  logic   ddr_wready,
    input  logic   host_s_valid,
    input  logic   csr_s_valid,
    input  logic   fifo_empty,
    input  logic   fifo_valid,
    input  logic   app_done,
    input  count_t inject_cnt,
    output logic   flush,
    output logic   irq
);

    // counts in stream words
    count_t host_cnt;
    count_t ddr_cnt;
    logic   irq_flag, irq_flag_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            host_cnt <= '0;
            ddr_cnt <= '0;
        end else begin
            if (pcis_wvalid && pcis_wready) host_cnt <= host_cnt + count_t'(WORDS_PER_LINE);
            if (ddr_wvalid && ddr_wready) ddr_cnt <= ddr_cnt + count_t'(WORDS_PER_LINE);
        end
    end

    assign flush = app_done && !host_s_valid && !csr_s_valid && fifo_empty && !fifo_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            irq_flag <= 1'b0;
            irq_flag_q <= 1'b0;
        end else begin
            if (flush && ddr_cnt >= host_cnt + inject_cnt) irq_flag <= 1'b1;
            irq_flag_q <= irq_flag;
        end
    end

    assign irq = irq_flag && !irq_flag_q;

endmodule

`default_nettype wire

// File: verilog/ddr_line_writer.sv
`default_nettype none

module ddr_line_writer import stream_app_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      fifo_valid,
    input  word_t     fifo_data,
    output logic      fifo_ready,
    input  logic      allow_writes,
    input  logic      flush,
    output logic      ddr_awvalid,
    output ddr_addr_t ddr_awaddr,
    input  logic      ddr_awready,
    output logic      ddr_wvalid,
    output line_t     ddr_wdata,
    input  logic      ddr_wready
);

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_COLLECT, ST_DATA} wr_state_t;

    wr_state_t state;
    line_t     line_q;
    ddr_addr_t addr_q;
    word_idx_t idx;
    logic      flush_sent;
    logic      word_acc;

    assign word_acc = fifo_valid && fifo_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
            flush_sent <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (allow_writes && !flush_sent) state <= ST_ADDR;
                ST_ADDR: if (ddr_awready) state <= ST_COLLECT;
                ST_COLLECT: begin
                    if (word_acc && idx == word_idx_t'(WORDS_PER_LINE - 1)) begin
                        state <= ST_DATA;
                    end else if (flush) begin
                        // partial line goes out with what has been collected
                        state <= ST_DATA;
                        flush_sent <= 1'b1;
                    end
                end
                ST_DATA: if (ddr_wready) state <= flush_sent ? ST_IDLE : ST_ADDR;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // unfilled positions keep the previous line
    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_q <= '0;
            idx <= '0;
        end else if (word_acc) begin
            line_q[idx*WORD_W +: WORD_W] <= fifo_data;
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) addr_q <= '0;
        else if (ddr_awvalid && ddr_awready) addr_q <= addr_q + ddr_addr_t'(LINE_BYTES);
    end

    assign fifo_ready = (state == ST_COLLECT);
    assign ddr_awvalid = (state == ST_ADDR);
    assign ddr_awaddr = addr_q;
    assign ddr_wvalid = (state == ST_DATA);
    assign ddr_wdata = line_q;

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
`default_nettype none

module stream_fifo import stream_app_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  arb_valid,
    input  word_t arb_data,
    output logic  arb_ready,
    output logic  fifo_valid,
    output word_t fifo_data,
    input  logic  fifo_ready,
    output logic  fifo_empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    word_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en, rd_en;

    assign wr_en = arb_valid && arb_ready;
    assign rd_en = fifo_valid && fifo_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= arb_data;
    end

    assign fifo_empty = (count == '0);
    assign fifo_valid = !fifo_empty;
    assign fifo_data = mem[rd_ptr];
    assign arb_ready = (count != (PTR_W+1)'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: verilog/stream_arbiter.sv
`default_nettype none

module stream_arbiter import stream_app_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  csr_s_valid,
    input  word_t csr_s_data,
    input  logic  csr_s_last,
    output logic  csr_s_ready,
    input  logic  host_s_valid,
    input  word_t host_s_data,
    input  logic  host_s_last,
    output logic  host_s_ready,
    output logic  arb_valid,
    output word_t arb_data,
    output logic  arb_last,
    input  logic  arb_ready
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_CSR, ARB_HOST} arb_state_t;

    arb_state_t state;
    logic       sel_csr;
    logic       xfer;

    // csr side wins only between packets
    assign sel_csr = (state == ARB_CSR) || (state == ARB_IDLE && csr_s_valid);
    assign xfer = arb_valid && arb_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else if (state == ARB_IDLE) begin
            if (xfer && !arb_last) state <= sel_csr ? ARB_CSR : ARB_HOST;
        end else if (xfer && arb_last) begin
            state <= ARB_IDLE;
        end
    end

    assign arb_valid = sel_csr ? csr_s_valid : host_s_valid;
    assign arb_data = sel_csr ? csr_s_data : host_s_data;
    assign arb_last = sel_csr ? csr_s_last : host_s_last;
    assign csr_s_ready = sel_csr && arb_ready;
    assign host_s_ready = !sel_csr && arb_ready;

endmodule

`default_nettype wire

// File: verilog/csr_write_slave.sv
`default_nettype none

module csr_write_slave import stream_app_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      csr_awvalid,
    input  csr_addr_t csr_awaddr,
    output logic      csr_awready,
    input  logic      csr_wvalid,
    input  word_t     csr_wdata,
    output logic      csr_wready,
    output logic      csr_bvalid,
    input  logic      csr_bready,
    output logic      csr_s_valid,
    output word_t     csr_s_data,
    output logic      csr_s_last,
    input  logic      csr_s_ready,
    output logic      allow_writes,
    output logic      app_done,
    output count_t    inject_cnt
);

    typedef enum logic [1:0] {W_IDLE, W_WAIT_W, W_STREAM, W_RESP} w_state_t;

    w_state_t  state, state_next;
    csr_addr_t addr_q;
    word_t     inject_q;
    logic      is_inject;
    logic      data_acc;

    assign is_inject = (addr_q == CSR_INJECT_ADDR);
    assign data_acc = csr_wvalid && csr_wready;

    always_comb begin
        state_next = state;
        case (state)
            W_IDLE:   if (csr_awvalid && csr_awready) state_next = W_WAIT_W;
            W_WAIT_W: if (data_acc) state_next = is_inject ? W_STREAM : W_RESP;
            W_STREAM: if (csr_s_valid && csr_s_ready) state_next = W_RESP;
            W_RESP:   if (csr_bvalid && csr_bready) state_next = W_IDLE;
            default:  state_next = W_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) state <= W_IDLE;
        else state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (csr_awvalid && csr_awready) addr_q <= csr_awaddr;
        if (data_acc && is_inject) inject_q <= csr_wdata;
    end

    // flags are sticky, unknown addresses fall through
    always_ff @(posedge clk) begin
        if (!rstn) begin
            allow_writes <= 1'b0;
            app_done <= 1'b0;
            inject_cnt <= '0;
        end else if (data_acc) begin
            case (addr_q)
                CSR_DONE_ADDR:   app_done <= 1'b1;
                CSR_ALLOW_ADDR:  allow_writes <= 1'b1;
                CSR_INJECT_ADDR: inject_cnt <= inject_cnt + 1'b1;
                default: ;
            endcase
        end
    end

    assign csr_awready = (state == W_IDLE);
    assign csr_wready = (state == W_WAIT_W);
    assign csr_bvalid = (state == W_RESP);

    // each inject is a one-word packet
    assign csr_s_valid = (state == W_STREAM);
    assign csr_s_data = inject_q;
    assign csr_s_last = csr_s_valid;

endmodule

`default_nettype wire

// File: verilog/pcis_write_slave.sv
`default_nettype none

module pcis_write_slave import stream_app_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       pcis_awvalid,
    input  axi_id_t    pcis_awid,
    input  burst_len_t pcis_awlen,
    output logic       pcis_awready,
    input  logic       pcis_wvalid,
    input  line_t      pcis_wdata,
    output logic       pcis_wready,
    output logic       pcis_bvalid,
    output axi_id_t    pcis_bid,
    input  logic       pcis_bready,
    output logic       host_s_valid,
    output word_t      host_s_data,
    output logic       host_s_last,
    input  logic       host_s_ready
);

    typedef enum logic [1:0] {AW_IDLE, AW_WAIT_W, AW_SENDB} aw_state_t;
    typedef enum logic {SP_IDLE, SP_TRANS} sp_state_t;

    aw_state_t  aw_state, aw_next;
    sp_state_t  sp_state;
    burst_len_t beats_left;
    axi_id_t    id_q;
    line_t      beat_q;
    word_idx_t  idx;
    logic       beat_acc;
    logic       word_acc;

    assign beat_acc = pcis_wvalid && pcis_wready;
    assign word_acc = host_s_valid && host_s_ready;

    always_comb begin
        aw_next = aw_state;
        case (aw_state)
            AW_IDLE:   if (pcis_awvalid && pcis_awready) aw_next = AW_WAIT_W;
            AW_WAIT_W: if (beat_acc && beats_left == '0) aw_next = AW_SENDB;
            AW_SENDB:  if (pcis_bvalid && pcis_bready) aw_next = AW_IDLE;
            default:   aw_next = AW_IDLE;
        endcase
    end

    // awready registered so it stays low in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_state <= AW_IDLE;
            pcis_awready <= 1'b0;
        end else begin
            aw_state <= aw_next;
            pcis_awready <= (aw_next == AW_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (aw_state == AW_IDLE && pcis_awvalid && pcis_awready) begin
            beats_left <= pcis_awlen;
            id_q <= pcis_awid;
        end else if (beat_acc) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // beat splitter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sp_state <= SP_IDLE;
            idx <= '0;
        end else if (sp_state == SP_IDLE) begin
            if (beat_acc) sp_state <= SP_TRANS;
        end else if (word_acc) begin
            idx <= idx + 1'b1;
            if (host_s_last) sp_state <= SP_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_acc) beat_q <= pcis_wdata;
    end

    assign pcis_wready = (sp_state == SP_IDLE) && (aw_state == AW_WAIT_W);
    assign pcis_bvalid = (aw_state == AW_SENDB);
    assign pcis_bid = id_q;

    assign host_s_valid = (sp_state == SP_TRANS);
    assign host_s_data = beat_q[idx*WORD_W +: WORD_W];
    assign host_s_last = (idx == word_idx_t'(WORDS_PER_LINE - 1));

endmodule

`default_nettype wire

// File: verilog/stream_app_pkg.sv
`default_nettype none

package stream_app_pkg;

    localparam int LINE_W = 128;
    localparam int WORD_W = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BYTES = 16;
    localparam int FIFO_DEPTH = 16;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_idx_t;
    typedef logic [63:0] ddr_addr_t;
    typedef logic [31:0] count_t;
    typedef logic [31:0] csr_addr_t;
    typedef logic [7:0] burst_len_t;
    typedef logic [5:0] axi_id_t;

    // register map, one word apart
    localparam csr_addr_t CSR_DONE_ADDR = 32'd4;
    localparam csr_addr_t CSR_INJECT_ADDR = 32'd8;
    localparam csr_addr_t CSR_ALLOW_ADDR = 32'd12;

endpackage

`default_nettype wire
